//--- logic/mips_pkg.sv
`default_nettype none

package mips_pkg;

    // **************************************************
    // widths and basic types
    // **************************************************

    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;

    typedef logic [data_w-1:0]     word_t;
    typedef logic [reg_addr_w-1:0] reg_addr_t;

    // register zero, never written.
    localparam reg_addr_t nop_reg_addr = '0;

    // read ports on the register file.
    localparam int num_read_ports = 2;

    // **************************************************
    // instruction fields
    // **************************************************

    localparam int opcode_hi = 31;
    localparam int opcode_lo = 26;
    localparam int rs_hi     = 25;
    localparam int rs_lo     = 21;
    localparam int rt_hi     = 20;
    localparam int rt_lo     = 16;
    localparam int rd_hi     = 15;
    localparam int rd_lo     = 11;
    localparam int shamt_hi  = 10;
    localparam int shamt_lo  = 6;
    localparam int funct_hi  = 5;
    localparam int funct_lo  = 0;
    localparam int imm_hi    = 15;
    localparam int imm_lo    = 0;

    // **************************************************
    // encodings
    // **************************************************

    typedef logic [5:0] opcode_t;
    typedef logic [5:0] funct_t;
    typedef logic [7:0] aluop_t;
    typedef logic [2:0] alusel_t;

    localparam opcode_t op_special = 6'b000000;
    localparam opcode_t op_ori     = 6'b001101;
    localparam opcode_t op_andi    = 6'b001100;
    localparam opcode_t op_xori    = 6'b001110;
    localparam opcode_t op_lui     = 6'b001111;

    // special opcode, selected by funct.
    localparam funct_t fn_or   = 6'b100101;
    localparam funct_t fn_and  = 6'b100100;
    localparam funct_t fn_xor  = 6'b100110;
    localparam funct_t fn_nor  = 6'b100111;
    localparam funct_t fn_sllv = 6'b000100;
    localparam funct_t fn_srlv = 6'b000110;
    localparam funct_t fn_srav = 6'b000111;
    localparam funct_t fn_sll  = 6'b000000;
    localparam funct_t fn_srl  = 6'b000010;
    localparam funct_t fn_sra  = 6'b000011;

    localparam aluop_t aluop_nop = 8'b00000000;
    localparam aluop_t aluop_or  = 8'b00100101;
    localparam aluop_t aluop_and = 8'b00100100;
    localparam aluop_t aluop_xor = 8'b00100110;
    localparam aluop_t aluop_nor = 8'b00100111;
    localparam aluop_t aluop_sll = 8'b01111100;
    localparam aluop_t aluop_srl = 8'b00000010;
    localparam aluop_t aluop_sra = 8'b00000011;

    // result group picked in execute.
    localparam alusel_t alusel_nop   = 3'b000;
    localparam alusel_t alusel_logic = 3'b001;
    localparam alusel_t alusel_shift = 3'b010;

endpackage

`default_nettype wire

//--- logic/inst_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
    input  logic               reset,
    input  mips_pkg::word_t    instruction,
    output logic               reg_read_enable [mips_pkg::num_read_ports],
    output mips_pkg::reg_addr_t reg_read_address [mips_pkg::num_read_ports],
    output mips_pkg::word_t    imm,
    output mips_pkg::aluop_t   aluop,
    output mips_pkg::alusel_t  alusel,
    output mips_pkg::reg_addr_t wreg_address,
    output logic               wreg_enable
);

    import mips_pkg::*;

    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    reg_addr_t shamt;
    funct_t    funct;
    logic [imm_hi-imm_lo:0] imm16;

    // instruction fields.
    assign opcode = instruction[opcode_hi:opcode_lo];
    assign rs     = instruction[rs_hi:rs_lo];
    assign rt     = instruction[rt_hi:rt_lo];
    assign rd     = instruction[rd_hi:rd_lo];
    assign shamt  = instruction[shamt_hi:shamt_lo];
    assign funct  = instruction[funct_hi:funct_lo];
    assign imm16  = instruction[imm_hi:imm_lo];

    always_comb begin
        // anything not matched below is a nop.
        aluop               = aluop_nop;
        alusel              = alusel_nop;
        wreg_enable         = 1'b0;
        wreg_address        = rd;
        reg_read_enable[0]  = 1'b0;
        reg_read_enable[1]  = 1'b0;
        reg_read_address[0] = rs;
        reg_read_address[1] = rt;
        imm                 = '0;

        if (reset) begin
            wreg_address        = nop_reg_addr;
            reg_read_address[0] = nop_reg_addr;
            reg_read_address[1] = nop_reg_addr;
        end else begin
            case (opcode)
                op_special: begin
                    // reg-reg ops need a zero shamt field.
                    if (shamt == '0) begin
                        wreg_enable        = 1'b1;
                        reg_read_enable[0] = 1'b1;
                        reg_read_enable[1] = 1'b1;
                        case (funct)
                            fn_or: begin
                                aluop  = aluop_or;
                                alusel = alusel_logic;
                            end
                            fn_and: begin
                                aluop  = aluop_and;
                                alusel = alusel_logic;
                            end
                            fn_xor: begin
                                aluop  = aluop_xor;
                                alusel = alusel_logic;
                            end
                            fn_nor: begin
                                aluop  = aluop_nor;
                                alusel = alusel_logic;
                            end
                            fn_sllv: begin
                                aluop  = aluop_sll;
                                alusel = alusel_shift;
                            end
                            fn_srlv: begin
                                aluop  = aluop_srl;
                                alusel = alusel_shift;
                            end
                            fn_srav: begin
                                aluop  = aluop_sra;
                                alusel = alusel_shift;
                            end
                            default: begin
                                wreg_enable        = 1'b0;
                                reg_read_enable[0] = 1'b0;
                                reg_read_enable[1] = 1'b0;
                            end
                        endcase
                    end
                end
                op_ori: begin
                    aluop              = aluop_or;
                    alusel             = alusel_logic;
                    wreg_enable        = 1'b1;
                    wreg_address       = rt;
                    reg_read_enable[0] = 1'b1;
                    imm                = word_t'(imm16);
                end
                op_andi: begin
                    aluop              = aluop_and;
                    alusel             = alusel_logic;
                    wreg_enable        = 1'b1;
                    wreg_address       = rt;
                    reg_read_enable[0] = 1'b1;
                    imm                = word_t'(imm16);
                end
                op_xori: begin
                    aluop              = aluop_xor;
                    alusel             = alusel_logic;
                    wreg_enable        = 1'b1;
                    wreg_address       = rt;
                    reg_read_enable[0] = 1'b1;
                    imm                = word_t'(imm16);
                end
                op_lui: begin
                    // or with the upper half.
                    aluop              = aluop_or;
                    alusel             = alusel_logic;
                    wreg_enable        = 1'b1;
                    wreg_address       = rt;
                    reg_read_enable[0] = 1'b1;
                    imm                = {imm16, {(data_w-$bits(imm16)){1'b0}}};
                end
                default: begin
                end
            endcase

            // immediate shifts override the decode above.
            if (instruction[opcode_hi:rs_lo] == '0) begin
                if (funct == fn_sll || funct == fn_srl || funct == fn_sra) begin
                    alusel             = alusel_shift;
                    wreg_enable        = 1'b1;
                    wreg_address       = rd;
                    reg_read_enable[0] = 1'b0;
                    reg_read_enable[1] = 1'b1;
                    imm                = word_t'(shamt);
                    if (funct == fn_sll) begin
                        aluop = aluop_sll;
                    end else if (funct == fn_srl) begin
                        aluop = aluop_srl;
                    end else begin
                        aluop = aluop_sra;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
    input  logic                reset,
    input  logic                read_enable,
    input  mips_pkg::reg_addr_t read_address,
    input  mips_pkg::word_t     reg_data,
    input  mips_pkg::word_t     imm,
    input  logic                ex_wreg_enable,
    input  mips_pkg::reg_addr_t ex_wreg_address,
    input  mips_pkg::word_t     ex_wreg_data,
    input  logic                mem_wreg_enable,
    input  mips_pkg::reg_addr_t mem_wreg_address,
    input  mips_pkg::word_t     mem_wreg_data,
    output mips_pkg::word_t     operand
);

    logic ex_hit;
    logic mem_hit;

    // pending writes to the register being read.
    assign ex_hit  = read_enable && ex_wreg_enable && (ex_wreg_address == read_address);
    assign mem_hit = read_enable && mem_wreg_enable && (mem_wreg_address == read_address);

    // youngest result wins.
    always_comb begin
        if (reset) begin
            operand = '0;
        end else if (ex_hit) begin
            operand = ex_wreg_data;
        end else if (mem_hit) begin
            operand = mem_wreg_data;
        end else if (read_enable) begin
            operand = reg_data;
        end else begin
            operand = imm;
        end
    end

endmodule

`default_nettype wire

//--- logic/id_ex_reg.sv
`timescale 1ns/1ps
`default_nettype none

module id_ex_reg (
    input  logic                clock,
    input  logic                reset,
    input  mips_pkg::aluop_t    aluop,
    input  mips_pkg::alusel_t   alusel,
    input  mips_pkg::word_t     reg1,
    input  mips_pkg::word_t     reg2,
    input  mips_pkg::reg_addr_t wreg_address,
    input  logic                wreg_enable,
    output mips_pkg::aluop_t    ex_aluop,
    output mips_pkg::alusel_t   ex_alusel,
    output mips_pkg::word_t     ex_reg1,
    output mips_pkg::word_t     ex_reg2,
    output mips_pkg::reg_addr_t ex_wreg_address,
    output logic                ex_wreg_enable
);

    import mips_pkg::*;

    // loads every cycle, no stall.
    always_ff @(posedge clock) begin
        if (reset) begin
            // bubble into execute.
            ex_aluop        <= aluop_nop;
            ex_alusel       <= alusel_nop;
            ex_reg1         <= '0;
            ex_reg2         <= '0;
            ex_wreg_address <= nop_reg_addr;
            ex_wreg_enable  <= 1'b0;
        end else begin
            ex_aluop        <= aluop;
            ex_alusel       <= alusel;
            ex_reg1         <= reg1;
            ex_reg2         <= reg2;
            ex_wreg_address <= wreg_address;
            ex_wreg_enable  <= wreg_enable;
        end
    end

endmodule

`default_nettype wire

//--- logic/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                clock,
    input  logic                reset,
    input  mips_pkg::word_t     pc,
    input  mips_pkg::word_t     instruction,
    // forward from the instruction now in execute.
    input  logic                ex_fwd_wreg_enable,
    input  mips_pkg::reg_addr_t ex_fwd_wreg_address,
    input  mips_pkg::word_t     ex_fwd_wreg_data,
    // forward from the memory stage.
    input  logic                mem_wreg_enable,
    input  mips_pkg::reg_addr_t mem_wreg_address,
    input  mips_pkg::word_t     mem_wreg_data,
    input  mips_pkg::word_t     reg1_data,
    input  mips_pkg::word_t     reg2_data,
    output logic                reg1_read,
    output logic                reg2_read,
    output mips_pkg::reg_addr_t reg1_address,
    output mips_pkg::reg_addr_t reg2_address,
    output mips_pkg::aluop_t    ex_aluop,
    output mips_pkg::alusel_t   ex_alusel,
    output mips_pkg::word_t     ex_reg1,
    output mips_pkg::word_t     ex_reg2,
    output mips_pkg::reg_addr_t ex_wreg_address,
    output logic                ex_wreg_enable
);

    import mips_pkg::*;

    logic      reg_read_enable [num_read_ports];
    reg_addr_t reg_read_address [num_read_ports];
    word_t     reg_data [num_read_ports];
    word_t     operand [num_read_ports];
    word_t     imm;
    aluop_t    aluop;
    alusel_t   alusel;
    reg_addr_t wreg_address;
    logic      wreg_enable;

    // pc rides along for later stages; decode ignores it.

    inst_decoder u_decoder (
        .reset            (reset),
        .instruction      (instruction),
        .reg_read_enable  (reg_read_enable),
        .reg_read_address (reg_read_address),
        .imm              (imm),
        .aluop            (aluop),
        .alusel           (alusel),
        .wreg_address     (wreg_address),
        .wreg_enable      (wreg_enable)
    );

    // register file ports.
    assign reg1_read    = reg_read_enable[0];
    assign reg2_read    = reg_read_enable[1];
    assign reg1_address = reg_read_address[0];
    assign reg2_address = reg_read_address[1];
    assign reg_data[0]  = reg1_data;
    assign reg_data[1]  = reg2_data;

    for (genvar i = 0; i < num_read_ports; i++) begin : g_operand
        operand_forward u_forward (
            .reset            (reset),
            .read_enable      (reg_read_enable[i]),
            .read_address     (reg_read_address[i]),
            .reg_data         (reg_data[i]),
            .imm              (imm),
            .ex_wreg_enable   (ex_fwd_wreg_enable),
            .ex_wreg_address  (ex_fwd_wreg_address),
            .ex_wreg_data     (ex_fwd_wreg_data),
            .mem_wreg_enable  (mem_wreg_enable),
            .mem_wreg_address (mem_wreg_address),
            .mem_wreg_data    (mem_wreg_data),
            .operand          (operand[i])
        );
    end

    id_ex_reg u_id_ex (
        .clock           (clock),
        .reset           (reset),
        .aluop           (aluop),
        .alusel          (alusel),
        .reg1            (operand[0]),
        .reg2            (operand[1]),
        .wreg_address    (wreg_address),
        .wreg_enable     (wreg_enable),
        .ex_aluop        (ex_aluop),
        .ex_alusel       (ex_alusel),
        .ex_reg1         (ex_reg1),
        .ex_reg2         (ex_reg2),
        .ex_wreg_address (ex_wreg_address),
        .ex_wreg_enable  (ex_wreg_enable)
    );

endmodule

`default_nettype wire

//--- testbench/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock (
    output logic clock,
    output logic reset
);

    // 10 ns period.
    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // held over two rising edges, dropped just after the second.
    initial begin
        reset = 1'b1;
        repeat (2) @(posedge clock);
        #1;
        reset = 1'b0;
    end

endmodule

`default_nettype wire

//--- testbench/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage;

    import mips_pkg::*;

    localparam int reset_timeout = 20;
    localparam int random_count  = 300;

    localparam funct_t  reg_functs [7]   = '{fn_or, fn_and, fn_xor, fn_nor,
                                             fn_sllv, fn_srlv, fn_srav};
    localparam opcode_t imm_opcodes [4]  = '{op_ori, op_andi, op_xori, op_lui};
    localparam funct_t  shift_functs [3] = '{fn_sll, fn_srl, fn_sra};

    typedef logic [31:0][data_w-1:0] reg_array_t;

    typedef struct packed {
        logic      rd1_en;
        logic      rd2_en;
        reg_addr_t rd1_addr;
        reg_addr_t rd2_addr;
        aluop_t    aluop;
        alusel_t   alusel;
        word_t     op1;
        word_t     op2;
        reg_addr_t waddr;
        logic      wen;
    } expect_t;

    logic      clock;
    logic      reset;
    word_t     pc;
    word_t     instruction;
    logic      ex_fwd_wreg_enable;
    reg_addr_t ex_fwd_wreg_address;
    word_t     ex_fwd_wreg_data;
    logic      mem_wreg_enable;
    reg_addr_t mem_wreg_address;
    word_t     mem_wreg_data;
    word_t     reg1_data;
    word_t     reg2_data;
    logic      reg1_read;
    logic      reg2_read;
    reg_addr_t reg1_address;
    reg_addr_t reg2_address;
    aluop_t    ex_aluop;
    alusel_t   ex_alusel;
    word_t     ex_reg1;
    word_t     ex_reg2;
    reg_addr_t ex_wreg_address;
    logic      ex_wreg_enable;

    reg_array_t reg_file;
    expect_t    cur_exp;
    int         error_count = 0;
    int         check_count = 0;

    tb_clock u_clock (
        .clock (clock),
        .reset (reset)
    );

    id_stage u_dut (
        .clock               (clock),
        .reset               (reset),
        .pc                  (pc),
        .instruction         (instruction),
        .ex_fwd_wreg_enable  (ex_fwd_wreg_enable),
        .ex_fwd_wreg_address (ex_fwd_wreg_address),
        .ex_fwd_wreg_data    (ex_fwd_wreg_data),
        .mem_wreg_enable     (mem_wreg_enable),
        .mem_wreg_address    (mem_wreg_address),
        .mem_wreg_data       (mem_wreg_data),
        .reg1_data           (reg1_data),
        .reg2_data           (reg2_data),
        .reg1_read           (reg1_read),
        .reg2_read           (reg2_read),
        .reg1_address        (reg1_address),
        .reg2_address        (reg2_address),
        .ex_aluop            (ex_aluop),
        .ex_alusel           (ex_alusel),
        .ex_reg1             (ex_reg1),
        .ex_reg2             (ex_reg2),
        .ex_wreg_address     (ex_wreg_address),
        .ex_wreg_enable      (ex_wreg_enable)
    );

    // register file model, read without a clock.
    assign reg1_data = reg_file[reg1_address];
    assign reg2_data = reg_file[reg2_address];

    // **************************************************
    // instruction builders
    // **************************************************

    function automatic word_t r_type(input reg_addr_t rs, input reg_addr_t rt,
                                     input reg_addr_t rd, input reg_addr_t sa,
                                     input funct_t fn);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t i_type(input opcode_t op, input reg_addr_t rs,
                                     input reg_addr_t rt, input logic [15:0] imm16);
        return {op, rs, rt, imm16};
    endfunction

    // small range so forwards hit often.
    function automatic reg_addr_t random_reg();
        return reg_addr_t'($urandom_range(0, 7));
    endfunction

    function automatic word_t random_kept_instruction();
        int        pick;
        reg_addr_t sa;
        pick = int'($urandom_range(0, 13));
        sa   = reg_addr_t'($urandom());
        if (pick < 7) begin
            return r_type(random_reg(), random_reg(), random_reg(), 5'd0, reg_functs[pick]);
        end else if (pick < 11) begin
            return i_type(imm_opcodes[pick-7], random_reg(), random_reg(), 16'($urandom()));
        end else begin
            return r_type(5'd0, random_reg(), random_reg(), sa, shift_functs[pick-11]);
        end
    endfunction

    // **************************************************
    // reference model
    // **************************************************

    function automatic word_t forward_operand(input logic en, input reg_addr_t addr,
                                              input word_t rdata, input word_t imm,
                                              input logic ex_en, input reg_addr_t ex_addr,
                                              input word_t ex_data, input logic mem_en,
                                              input reg_addr_t mem_addr, input word_t mem_data);
        if (en && ex_en && ex_addr == addr) begin
            return ex_data;
        end
        if (en && mem_en && mem_addr == addr) begin
            return mem_data;
        end
        return en ? rdata : imm;
    endfunction

    function automatic expect_t bubble_expect();
        expect_t e;
        e = '0;
        e.aluop  = aluop_nop;
        e.alusel = alusel_nop;
        return e;
    endfunction

    function automatic expect_t reference_decode(input word_t instr,
                                                 input logic ex_en, input reg_addr_t ex_addr,
                                                 input word_t ex_data,
                                                 input logic mem_en, input reg_addr_t mem_addr,
                                                 input word_t mem_data,
                                                 input reg_array_t regs);
        expect_t   e;
        opcode_t   op;
        funct_t    fn;
        reg_addr_t sa;
        word_t     imm;
        op = instr[31:26];
        fn = instr[5:0];
        sa = instr[10:6];
        e  = bubble_expect();
        e.rd1_addr = instr[25:21];
        e.rd2_addr = instr[20:16];
        e.waddr    = instr[15:11];
        imm        = '0;

        if (instr[31:21] == 11'd0 && (fn == fn_sll || fn == fn_srl || fn == fn_sra)) begin
            e.rd2_en = 1'b1;
            e.wen    = 1'b1;
            e.alusel = alusel_shift;
            e.aluop  = (fn == fn_sll) ? aluop_sll : ((fn == fn_srl) ? aluop_srl : aluop_sra);
            imm      = word_t'(sa);
        end else if (op == op_special && sa == 5'd0) begin
            case (fn)
                fn_or:   e.aluop = aluop_or;
                fn_and:  e.aluop = aluop_and;
                fn_xor:  e.aluop = aluop_xor;
                fn_nor:  e.aluop = aluop_nor;
                fn_sllv: e.aluop = aluop_sll;
                fn_srlv: e.aluop = aluop_srl;
                fn_srav: e.aluop = aluop_sra;
                default: e.aluop = aluop_nop;
            endcase
            if (e.aluop != aluop_nop) begin
                e.rd1_en = 1'b1;
                e.rd2_en = 1'b1;
                e.wen    = 1'b1;
                e.alusel = (fn[5] == 1'b1) ? alusel_logic : alusel_shift;
            end
        end else if (op == op_ori || op == op_andi || op == op_xori || op == op_lui) begin
            e.rd1_en = 1'b1;
            e.wen    = 1'b1;
            e.waddr  = instr[20:16];
            e.alusel = alusel_logic;
            if (op == op_lui) begin
                e.aluop = aluop_or;
                imm     = {instr[15:0], 16'h0000};
            end else begin
                e.aluop = (op == op_ori) ? aluop_or : ((op == op_andi) ? aluop_and : aluop_xor);
                imm     = {16'h0000, instr[15:0]};
            end
        end

        e.op1 = forward_operand(e.rd1_en, e.rd1_addr, regs[e.rd1_addr], imm,
                                ex_en, ex_addr, ex_data, mem_en, mem_addr, mem_data);
        e.op2 = forward_operand(e.rd2_en, e.rd2_addr, regs[e.rd2_addr], imm,
                                ex_en, ex_addr, ex_data, mem_en, mem_addr, mem_data);
        return e;
    endfunction

    // **************************************************
    // stimulus and checking
    // **************************************************

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: got 0x%08h expected 0x%08h at %0t",
                     name, got, expected, $time);
        end
    endtask

    task automatic apply_instruction(input word_t instr,
                                     input logic ex_en, input reg_addr_t ex_addr,
                                     input word_t ex_data,
                                     input logic mem_en, input reg_addr_t mem_addr,
                                     input word_t mem_data);
        @(posedge clock);
        #1;
        pc                  = pc + 32'd4;
        instruction         = instr;
        ex_fwd_wreg_enable  = ex_en;
        ex_fwd_wreg_address = ex_addr;
        ex_fwd_wreg_data    = ex_data;
        mem_wreg_enable     = mem_en;
        mem_wreg_address    = mem_addr;
        mem_wreg_data       = mem_data;
        cur_exp = reference_decode(instr, ex_en, ex_addr, ex_data,
                                   mem_en, mem_addr, mem_data, reg_file);
    endtask

    task automatic apply_plain(input word_t instr);
        apply_instruction(instr, 1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0);
    endtask

    // comb outputs against this cycle, registered ones against the last.
    initial begin : compare_outputs
        expect_t now_exp;
        expect_t prev_exp;
        prev_exp = bubble_expect();
        @(posedge clock);
        forever begin
            @(negedge clock);
            now_exp = (reset !== 1'b0) ? bubble_expect() : cur_exp;
            check_value("reg1_read", 32'(reg1_read), 32'(now_exp.rd1_en));
            check_value("reg2_read", 32'(reg2_read), 32'(now_exp.rd2_en));
            check_value("reg1_address", 32'(reg1_address), 32'(now_exp.rd1_addr));
            check_value("reg2_address", 32'(reg2_address), 32'(now_exp.rd2_addr));
            check_value("ex_aluop", 32'(ex_aluop), 32'(prev_exp.aluop));
            check_value("ex_alusel", 32'(ex_alusel), 32'(prev_exp.alusel));
            check_value("ex_reg1", ex_reg1, prev_exp.op1);
            check_value("ex_reg2", ex_reg2, prev_exp.op2);
            check_value("ex_wreg_address", 32'(ex_wreg_address), 32'(prev_exp.waddr));
            check_value("ex_wreg_enable", 32'(ex_wreg_enable), 32'(prev_exp.wen));
            prev_exp = now_exp;
        end
    end

    initial begin : stimulus
        int    seed_value;
        int    wait_cycles;
        word_t instr;
        seed_value = $urandom(32'hb5fac345);
        for (int i = 0; i < 32; i++) begin
            reg_file[i] = (i == 0) ? 32'd0 : $urandom();
        end
        pc                  = '0;
        instruction         = r_type(5'd1, 5'd2, 5'd3, 5'd0, fn_or);
        ex_fwd_wreg_enable  = 1'b0;
        ex_fwd_wreg_address = '0;
        ex_fwd_wreg_data    = '0;
        mem_wreg_enable     = 1'b0;
        mem_wreg_address    = '0;
        mem_wreg_data       = '0;
        cur_exp = reference_decode(instruction, 1'b0, 5'd0, 32'd0, 1'b0, 5'd0, 32'd0, reg_file);

        wait_cycles = 0;
        while (reset !== 1'b0 && wait_cycles < reset_timeout) begin
            @(negedge clock);
            wait_cycles++;
        end

        if (reset !== 1'b0) begin
            error_count++;
            $display("timeout: reset still asserted after %0d cycles", wait_cycles);
        end else begin
            // reg-reg logic ops and variable shifts.
            for (int i = 0; i < 7; i++) begin
                apply_plain(r_type(random_reg(), random_reg(), 5'(8 + i), 5'd0, reg_functs[i]));
            end
            // immediate ops and lui.
            for (int i = 0; i < 4; i++) begin
                apply_plain(i_type(imm_opcodes[i], 5'(i + 1), 5'(20 + i), 16'($urandom())));
            end
            // immediate shifts.
            for (int i = 0; i < 3; i++) begin
                apply_plain(r_type(5'd0, 5'(4 + i), 5'(16 + i), 5'(3 * i + 1), shift_functs[i]));
            end

            // forwarding priority.
            instr = r_type(5'd3, 5'd7, 5'd12, 5'd0, fn_or);
            apply_instruction(instr, 1'b1, 5'd3, 32'hdead0001, 1'b1, 5'd3, 32'hbeef0001);
            apply_instruction(instr, 1'b1, 5'd20, 32'hdead0002, 1'b1, 5'd7, 32'hbeef0002);
            apply_instruction(instr, 1'b1, 5'd20, 32'hdead0003, 1'b1, 5'd21, 32'hbeef0003);
            apply_instruction(instr, 1'b1, 5'd7, 32'hdead0004, 1'b1, 5'd3, 32'hbeef0004);
            apply_instruction(instr, 1'b0, 5'd3, 32'hdead0005, 1'b1, 5'd3, 32'hbeef0005);
            apply_instruction(i_type(op_ori, 5'd5, 5'd9, 16'h1234),
                              1'b1, 5'd9, 32'hdead0006, 1'b1, 5'd9, 32'hbeef0006);
            apply_instruction(r_type(5'd0, 5'd6, 5'd13, 5'd4, fn_sll),
                              1'b1, 5'd6, 32'hdead0007, 1'b0, 5'd0, 32'd0);

            // undefined encodings.
            apply_plain(i_type(6'b100011, 5'd2, 5'd4, 16'h0010));
            apply_plain(i_type(6'b000010, 5'd1, 5'd1, 16'hffff));
            apply_plain(r_type(5'd1, 5'd2, 5'd3, 5'd0, 6'b100000));
            apply_plain(r_type(5'd1, 5'd2, 5'd3, 5'd5, fn_or));

            for (int n = 0; n < random_count; n++) begin
                instr = (n % 2 == 0) ? $urandom() : random_kept_instruction();
                apply_instruction(instr, 1'($urandom()), random_reg(), $urandom(),
                                  1'($urandom()), random_reg(), $urandom());
            end

            // let the last capture reach the checker.
            repeat (3) @(posedge clock);
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
logic/mips_pkg.sv
logic/inst_decoder.sv
logic/operand_forward.sv
logic/id_ex_reg.sv
logic/id_stage.sv
testbench/tb_clock.sv
testbench/tb_id_stage.sv

//--- run.sh
#!/usr/bin/env bash
# compile with verilator, run, and look for the pass line in the output.

cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_id_stage -f sim.f &&
./obj_dir/Vtb_id_stage | tee /dev/stderr | grep -x "ALL TESTS PASSED" > /dev/null &&
echo "simulation passed" ||
{
    echo "simulation failed"
    exit 1
}
